// ==== mmt_chain_multiplier.sv ====
`timescale 1ns/1ps
`include "mmt_defines.svh"

module mmt_chain_multiplier (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 load_done,
	input  mmt_ctrl_pkg::dim_t   dim,
	input  mmt_data_pkg::elem_t  op_a [`MMT_MAX_N][`MMT_MAX_N],
	input  mmt_data_pkg::elem_t  op_b [`MMT_MAX_N][`MMT_MAX_N],
	input  mmt_data_pkg::elem_t  op_c [`MMT_MAX_N][`MMT_MAX_N],
	output mmt_data_pkg::trace_t trace,
	output logic                 trace_done
);
	import mmt_data_pkg::*;
	import mmt_ctrl_pkg::*;

	localparam int N  = `MMT_MAX_N;
	localparam int RW = $clog2(`MMT_MAX_N);

	mult_state_t   state;
	logic [1:0]    step;
	logic [RW-1:0] row;
	logic          row_last;
	logic          row_end;
	mid_t          ab    [N][N];
	mid_t          x_vec [N];
	elem_t         y_vec [N][N];
	trace_t        dot   [N];

	assign row_last = (dim_t'(row) == dim - 3'd1);
	// Dot result for the held row lands on the third cycle
	assign row_end  = (step == 2'd2);

	//////////////////////////////
	// Operand select per pass
	//////////////////////////////
	always_comb begin
		for (int k = 0; k < N; k++) begin
			x_vec[k] = (state == MU_PASS2) ? ab[row][k] : mid_t'(op_a[row][k]);
			for (int j = 0; j < N; j++) begin
				y_vec[j][k] = (state == MU_PASS2) ? op_c[k][j] : op_b[k][j];
			end
		end
	end

	// One dot unit per result column
	for (genvar j = 0; j < N; j++) begin : g_col
		mmt_dot_row dot_row_inst (
			.clk (clk),
			.x   (x_vec),
			.y   (y_vec[j]),
			.dot (dot[j])
		);
	end

	//////////////////////////////
	// Row sequencer and trace sum
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= MU_IDLE;
			step       <= '0;
			row        <= '0;
			trace      <= '0;
			trace_done <= 1'b0;
		end else begin
			trace_done <= 1'b0;
			case (state)
				MU_IDLE: begin
					if (load_done) begin
						state <= MU_PASS1;
						step  <= '0;
						row   <= '0;
						trace <= '0;
					end
				end
				MU_PASS1, MU_PASS2: begin
					if (row_end) begin
						step <= '0;
						// only the diagonal term of (A*B)*C matters
						if (state == MU_PASS2)
							trace <= trace + dot[row];
						if (row_last) begin
							row <= '0;
							if (state == MU_PASS1) begin
								state <= MU_PASS2;
							end else begin
								state      <= MU_IDLE;
								trace_done <= 1'b1;
							end
						end else begin
							row <= row + 1'b1;
						end
					end else begin
						step <= step + 2'd1;
					end
				end
				default: state <= MU_IDLE;
			endcase
		end
	end

	// First product, one row per three cycles
	always_ff @(posedge clk) begin
		if (state == MU_PASS1 && row_end) begin
			for (int j = 0; j < N; j++) begin
				ab[row][j] <= mid_t'(dot[j]);
			end
		end
	end

endmodule

// ==== mmt_ctrl_pkg.sv ====
package mmt_ctrl_pkg;

	// Size code from the first burst beat
	typedef logic [1:0] size_code_t;

	localparam size_code_t SIZE_2X2 = 2'd0;

	// Which operand is transposed
	typedef enum logic [1:0] {
		MODE_PLAIN,
		MODE_T_FIRST,
		MODE_T_SECOND,
		MODE_T_THIRD
	} mode_t;

	// Matrix dimension, 2 or 4
	typedef logic [2:0] dim_t;

	localparam dim_t DIM_SMALL = 3'd2;
	localparam dim_t DIM_LARGE = 3'd4;

	typedef enum logic {LD_IDX, LD_READ} load_state_t;

	typedef enum logic [1:0] {MU_IDLE, MU_PASS1, MU_PASS2} mult_state_t;

endpackage

// ==== mmt_data_pkg.sv ====
`include "mmt_defines.svh"

package mmt_data_pkg;

	// Signed element as stored
	typedef logic signed [`MMT_ELEM_W-1:0] elem_t;

	// Entry of the first product
	typedef logic signed [`MMT_MID_W-1:0] mid_t;

	// Final trace and dot sums
	typedef logic signed [`MMT_OUT_W-1:0] trace_t;

	// Matrix number inside the store
	typedef logic [2:0] mat_idx_t;

	// Row-major position inside one matrix
	typedef logic [3:0] elem_addr_t;

endpackage

// ==== mmt_defines.svh ====
`ifndef MMT_DEFINES_SVH
`define MMT_DEFINES_SVH

// Largest supported matrix dimension
`define MMT_MAX_N 4

// Matrices held in the store per session
`define MMT_NUM_MATS 8

// Stored element width
`define MMT_ELEM_W 8

// Width of one A*B entry
`define MMT_MID_W 20

// Width of the returned trace
`define MMT_OUT_W 32

// Requests served before the store reopens
`define MMT_ROUNDS 10

`endif

// ==== mmt_dot_row.sv ====
`timescale 1ns/1ps
`include "mmt_defines.svh"

module mmt_dot_row (
	input  logic                 clk,
	input  mmt_data_pkg::mid_t   x [`MMT_MAX_N],
	input  mmt_data_pkg::elem_t  y [`MMT_MAX_N],
	output mmt_data_pkg::trace_t dot
);
	import mmt_data_pkg::*;

	localparam int N = `MMT_MAX_N;

	mid_t   x_q  [N];
	elem_t  y_q  [N];
	trace_t prod [N];

	// Operand stage then product stage
	always_ff @(posedge clk) begin
		x_q <= x;
		y_q <= y;
		for (int k = 0; k < N; k++) begin
			prod[k] <= x_q[k] * y_q[k];
		end
	end

	// Adder tree after the product registers
	always_comb begin
		dot = '0;
		for (int k = 0; k < N; k++) begin
			dot = dot + prod[k];
		end
	end

endmodule

// ==== mmt_input_store.sv ====
`timescale 1ns/1ps
`include "mmt_defines.svh"

module mmt_input_store (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	input  mmt_data_pkg::elem_t      matrix,
	input  mmt_ctrl_pkg::size_code_t matrix_size,
	input  logic                     session_end,
	input  mmt_data_pkg::mat_idx_t   rd_mat,
	input  mmt_data_pkg::elem_addr_t rd_pos,
	output mmt_ctrl_pkg::dim_t       dim,
	output mmt_data_pkg::elem_t      rd_data
);
	import mmt_data_pkg::*;
	import mmt_ctrl_pkg::*;

	localparam int DEPTH = `MMT_NUM_MATS * `MMT_MAX_N * `MMT_MAX_N;

	elem_t      mem [DEPTH];
	logic       open;
	logic       in_valid_d;
	logic       first_beat;
	logic       wr_en;
	elem_t      wr_data;
	mat_idx_t   wr_mat;
	elem_addr_t wr_pos;
	logic [5:0] area;
	logic       pos_wrap;

	assign first_beat = in_valid && !in_valid_d && open;
	assign area       = dim * dim;
	assign pos_wrap   = ({2'b00, wr_pos} == area - 6'd1);

	//////////////////////////////
	// Burst capture and counters
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			open       <= 1'b1;
			in_valid_d <= 1'b0;
			wr_en      <= 1'b0;
			dim        <= DIM_SMALL;
			wr_mat     <= '0;
			wr_pos     <= '0;
		end else begin
			in_valid_d <= in_valid;
			wr_en      <= in_valid && open;
			// Closed from burst end until the last request of the session
			if (session_end)
				open <= 1'b1;
			else if (in_valid_d && !in_valid && open)
				open <= 1'b0;
			if (first_beat) begin
				dim    <= (matrix_size == SIZE_2X2) ? DIM_SMALL : DIM_LARGE;
				wr_mat <= '0;
				wr_pos <= '0;
			end else if (wr_en) begin
				if (pos_wrap) begin
					wr_pos <= '0;
					wr_mat <= wr_mat + 3'd1;
				end else begin
					wr_pos <= wr_pos + 4'd1;
				end
			end
		end
	end

	//////////////////////////////
	// Storage array
	//////////////////////////////
	always_ff @(posedge clk) begin
		wr_data <= matrix;
		if (wr_en)
			mem[{wr_mat, wr_pos}] <= wr_data;
		// One cycle read latency for the loader
		rd_data <= mem[{rd_mat, rd_pos}];
	end

endmodule

// ==== mmt_operand_loader.sv ====
`timescale 1ns/1ps
`include "mmt_defines.svh"

module mmt_operand_loader (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid2,
	input  mmt_data_pkg::mat_idx_t   matrix_idx,
	input  mmt_ctrl_pkg::mode_t      mode,
	input  mmt_ctrl_pkg::dim_t       dim,
	input  mmt_data_pkg::elem_t      rd_data,
	output mmt_data_pkg::mat_idx_t   rd_mat,
	output mmt_data_pkg::elem_addr_t rd_pos,
	output mmt_data_pkg::elem_t      op_a [`MMT_MAX_N][`MMT_MAX_N],
	output mmt_data_pkg::elem_t      op_b [`MMT_MAX_N][`MMT_MAX_N],
	output mmt_data_pkg::elem_t      op_c [`MMT_MAX_N][`MMT_MAX_N],
	output logic                     load_done
);
	import mmt_data_pkg::*;
	import mmt_ctrl_pkg::*;

	localparam int RW = $clog2(`MMT_MAX_N);

	load_state_t    state;
	logic [1:0]     beat_cnt;
	mat_idx_t       idx_q [3];
	mode_t          mode_q;
	logic [1:0]     slot;
	elem_addr_t     pos;
	logic [5:0]     area;
	logic           last_rd;
	logic           start;
	logic           rd_vld_q;
	logic [1:0]     slot_q;
	elem_addr_t     pos_q;
	logic [RW-1:0]  row;
	logic [RW-1:0]  col;
	logic           swap;
	logic [RW-1:0]  dst_r;
	logic [RW-1:0]  dst_c;

	assign area    = dim * dim;
	assign last_rd = (slot == 2'd2) && ({2'b00, pos} == area - 6'd1);
	assign start   = (state == LD_IDX) && in_valid2 && (beat_cnt == 2'd2);
	// One matrix per read slot
	assign rd_mat  = idx_q[slot];
	assign rd_pos  = pos;

	//////////////////////////////
	// Index capture and read sequence
	//////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= LD_IDX;
			beat_cnt <= '0;
			idx_q    <= '{default: '0};
			mode_q   <= MODE_PLAIN;
			slot     <= '0;
			pos      <= '0;
		end else begin
			case (state)
				LD_IDX: begin
					if (in_valid2) begin
						idx_q[beat_cnt] <= matrix_idx;
						if (beat_cnt == 2'd0)
							mode_q <= mode;
						if (start) begin
							beat_cnt <= '0;
							state    <= LD_READ;
						end else begin
							beat_cnt <= beat_cnt + 2'd1;
						end
					end
				end
				LD_READ: begin
					if (slot == 2'd2) begin
						slot <= '0;
						if (last_rd) begin
							pos   <= '0;
							state <= LD_IDX;
						end else begin
							pos <= pos + 4'd1;
						end
					end else begin
						slot <= slot + 2'd1;
					end
				end
				default: state <= LD_IDX;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_vld_q  <= 1'b0;
			load_done <= 1'b0;
		end else begin
			rd_vld_q  <= (state == LD_READ);
			load_done <= (state == LD_READ) && last_rd;
		end
	end

	always_ff @(posedge clk) begin
		slot_q <= slot;
		pos_q  <= pos;
	end

	//////////////////////////////
	// Placement with transpose
	//////////////////////////////
	always_comb begin
		if (dim == DIM_SMALL) begin
			row = RW'(pos_q[1]);
			col = RW'(pos_q[0]);
		end else begin
			row = pos_q[3:2];
			col = pos_q[1:0];
		end
		case (slot_q)
			2'd0:    swap = (mode_q == MODE_T_FIRST);
			2'd1:    swap = (mode_q == MODE_T_SECOND);
			default: swap = (mode_q == MODE_T_THIRD);
		endcase
		dst_r = swap ? col : row;
		dst_c = swap ? row : col;
	end

	// Cleared at request start so unused rows and columns read zero
	always_ff @(posedge clk) begin
		if (start) begin
			op_a <= '{default: '0};
			op_b <= '{default: '0};
			op_c <= '{default: '0};
		end else if (rd_vld_q) begin
			case (slot_q)
				2'd0:    op_a[dst_r][dst_c] <= rd_data;
				2'd1:    op_b[dst_r][dst_c] <= rd_data;
				default: op_c[dst_r][dst_c] <= rd_data;
			endcase
		end
	end

endmodule

// ==== mmt_session_ctrl.sv ====
`timescale 1ns/1ps
`include "mmt_defines.svh"

module mmt_session_ctrl (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 trace_done,
	input  mmt_data_pkg::trace_t trace,
	output logic                 out_valid,
	output mmt_data_pkg::trace_t out_value,
	output logic                 session_end
);
	localparam int RCW = $clog2(`MMT_ROUNDS);

	logic [RCW-1:0] round_cnt;
	logic           last_round;

	assign last_round = (round_cnt == RCW'(`MMT_ROUNDS - 1));

	// Output register, zero outside the valid cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_value <= '0;
		end else begin
			out_valid <= trace_done;
			out_value <= trace_done ? trace : '0;
		end
	end

	// Request counter
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			round_cnt   <= '0;
			session_end <= 1'b0;
		end else begin
			session_end <= trace_done && last_round;
			if (trace_done)
				round_cnt <= last_round ? '0 : round_cnt + 1'b1;
		end
	end

endmodule

// ==== mmt_top.sv ====
`timescale 1ns/1ps
`include "mmt_defines.svh"

module mmt_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	input  logic                     in_valid2,
	input  mmt_data_pkg::elem_t      matrix,
	input  mmt_ctrl_pkg::size_code_t matrix_size,
	input  mmt_data_pkg::mat_idx_t   matrix_idx,
	input  mmt_ctrl_pkg::mode_t      mode,
	output logic                     out_valid,
	output mmt_data_pkg::trace_t     out_value
);
	mmt_ctrl_pkg::dim_t       dim;
	mmt_data_pkg::mat_idx_t   rd_mat;
	mmt_data_pkg::elem_addr_t rd_pos;
	mmt_data_pkg::elem_t      rd_data;
	mmt_data_pkg::elem_t      op_a [`MMT_MAX_N][`MMT_MAX_N];
	mmt_data_pkg::elem_t      op_b [`MMT_MAX_N][`MMT_MAX_N];
	mmt_data_pkg::elem_t      op_c [`MMT_MAX_N][`MMT_MAX_N];
	logic                     load_done;
	mmt_data_pkg::trace_t     trace;
	logic                     trace_done;
	logic                     session_end;

	mmt_input_store input_store_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.matrix      (matrix),
		.matrix_size (matrix_size),
		.session_end (session_end),
		.rd_mat      (rd_mat),
		.rd_pos      (rd_pos),
		.dim         (dim),
		.rd_data     (rd_data)
	);

	mmt_operand_loader operand_loader_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid2  (in_valid2),
		.matrix_idx (matrix_idx),
		.mode       (mode),
		.dim        (dim),
		.rd_data    (rd_data),
		.rd_mat     (rd_mat),
		.rd_pos     (rd_pos),
		.op_a       (op_a),
		.op_b       (op_b),
		.op_c       (op_c),
		.load_done  (load_done)
	);

	mmt_chain_multiplier chain_multiplier_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.load_done  (load_done),
		.dim        (dim),
		.op_a       (op_a),
		.op_b       (op_b),
		.op_c       (op_c),
		.trace      (trace),
		.trace_done (trace_done)
	);

	mmt_session_ctrl session_ctrl_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.trace_done  (trace_done),
		.trace       (trace),
		.out_valid   (out_valid),
		.out_value   (out_value),
		.session_end (session_end)
	);

endmodule

// ==== sim.f ====
+incdir+.
mmt_data_pkg.sv
mmt_ctrl_pkg.sv
mmt_input_store.sv
mmt_operand_loader.sv
mmt_dot_row.sv
mmt_chain_multiplier.sv
mmt_session_ctrl.sv
mmt_top.sv
tb_mmt_clkgen.sv
tb_mmt.sv

// ==== tb_mmt.sv ====
`timescale 1ns/1ps
`include "mmt_defines.svh"

module tb_mmt;
	import mmt_data_pkg::*;
	import mmt_ctrl_pkg::*;

	localparam int NUM_ROWS     = 25;
	localparam int BURST_CYCLES = `MMT_NUM_MATS * `MMT_MAX_N * `MMT_MAX_N + 4;
	// Beats, three reads per position, two passes of three cycles per row
	localparam int REQ_CYCLES   = 3 + 3 * `MMT_MAX_N * `MMT_MAX_N + 6 * `MMT_MAX_N + 8;
	localparam int ROW_CYCLES   = (BURST_CYCLES > REQ_CYCLES) ? BURST_CYCLES : REQ_CYCLES;
	localparam int CYCLE_LIMIT  = NUM_ROWS * ROW_CYCLES + 20;

	typedef struct packed {
		logic        is_session;
		logic [1:0]  size_code;
		logic [2:0]  idx_a;
		logic [2:0]  idx_b;
		logic [2:0]  idx_c;
		logic [1:0]  mode_val;
		logic [15:0] pats;
	} stim_row_t;

	logic       clk;
	logic       rst_n;
	logic       in_valid;
	logic       in_valid2;
	elem_t      matrix;
	size_code_t matrix_size;
	mat_idx_t   matrix_idx;
	mode_t      mode;
	logic       out_valid;
	trace_t     out_value;

	stim_row_t stim [NUM_ROWS];
	int        mats [`MMT_NUM_MATS][`MMT_MAX_N][`MMT_MAX_N];
	int        dim_cur;
	int        cycle_cnt;
	int        pulse_cnt;
	int        req_done;
	int        err_cnt;
	bit        valid_prev;

	tb_mmt_clkgen clkgen_inst (
		.clk   (clk),
		.rst_n (rst_n)
	);

	mmt_top mmt_top_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.in_valid2   (in_valid2),
		.matrix      (matrix),
		.matrix_size (matrix_size),
		.matrix_idx  (matrix_idx),
		.mode        (mode),
		.out_valid   (out_valid),
		.out_value   (out_value)
	);

	//////////////////////////////
	// Error reporting
	//////////////////////////////
	task automatic fail_value(input string sig, input longint exp, input longint act);
		err_cnt++;
		$display("FAIL time=%0t signal=%s expected=%0d actual=%0d", $time, sig, exp, act);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic fail_text(input string msg);
		err_cnt++;
		$display("%s at time %0t", msg, $time);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first error");
	endtask

	//////////////////////////////
	// Stimulus table rows
	//////////////////////////////
	// Two pattern bits per matrix: 0 random, 1 all -128, 2 all 127
	function automatic stim_row_t session_row(input logic [1:0] size, input logic [15:0] pats);
		stim_row_t r;
		r            = '0;
		r.is_session = 1'b1;
		r.size_code  = size;
		r.pats       = pats;
		return r;
	endfunction

	function automatic stim_row_t request_row(input int a, input int b, input int c, input int m);
		stim_row_t r;
		r          = '0;
		r.idx_a    = 3'(a);
		r.idx_b    = 3'(b);
		r.idx_c    = 3'(c);
		r.mode_val = 2'(m);
		return r;
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////
	function automatic int element(input int m, input bit tr, input int r, input int c);
		return tr ? mats[m][c][r] : mats[m][r][c];
	endfunction

	// trace(A*B*C), the mode picks which operand is transposed
	function automatic longint model_trace(input int ia, input int ib, input int ic, input int md);
		longint acc;
		longint ab;
		acc = 0;
		for (int i = 0; i < dim_cur; i++) begin
			for (int l = 0; l < dim_cur; l++) begin
				ab = 0;
				for (int k = 0; k < dim_cur; k++)
					ab += element(ia, md == 1, i, k) * element(ib, md == 2, k, l);
				acc += ab * element(ic, md == 3, l, i);
			end
		end
		return acc;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	//////////////////////////////
	// Burst and request drivers
	//////////////////////////////
	task automatic load_session(input logic [1:0] size, input logic [15:0] pats);
		logic [1:0] pat;
		logic [7:0] raw;
		dim_cur = (size == 2'd0) ? 2 : 4;
		for (int m = 0; m < `MMT_NUM_MATS; m++) begin
			pat = pats[2*m +: 2];
			for (int r = 0; r < dim_cur; r++) begin
				for (int c = 0; c < dim_cur; c++) begin
					raw = 8'($urandom());
					case (pat)
						2'd1:    mats[m][r][c] = -128;
						2'd2:    mats[m][r][c] = 127;
						default: mats[m][r][c] = $signed(raw);
					endcase
					next_cycle();
					in_valid    = 1'b1;
					matrix_size = size;
					matrix      = elem_t'(mats[m][r][c]);
				end
			end
		end
		next_cycle();
		in_valid = 1'b0;
		matrix   = '0;
		// Last writes land two cycles after their beat
		repeat (2) next_cycle();
	endtask

	task automatic run_request(input stim_row_t row);
		mat_idx_t idx [3];
		trace_t   expected;
		trace_t   got;
		idx[0]   = row.idx_a;
		idx[1]   = row.idx_b;
		idx[2]   = row.idx_c;
		expected = trace_t'(model_trace(row.idx_a, row.idx_b, row.idx_c, row.mode_val));
		for (int b = 0; b < 3; b++) begin
			next_cycle();
			in_valid2  = 1'b1;
			matrix_idx = idx[b];
			mode       = mode_t'(row.mode_val);
		end
		next_cycle();
		in_valid2  = 1'b0;
		matrix_idx = '0;
		// Bounded by the cycle limit below
		while (out_valid !== 1'b1)
			next_cycle();
		got = out_value;
		req_done++;
		assert (got === expected) else fail_value("out_value", expected, got);
		next_cycle();
		assert (pulse_cnt == req_done)
			else fail_text("Request did not give exactly one out_valid pulse");
	endtask

	//////////////////////////////
	// Output monitor and timeout
	//////////////////////////////
	always @(negedge clk) begin
		if (rst_n) begin
			if (out_valid) begin
				assert (!valid_prev) else fail_value("out_valid", 0, 1);
				pulse_cnt++;
			end else begin
				assert (out_value === '0) else fail_value("out_value", 0, out_value);
			end
			valid_prev = out_valid;
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT)
			fail_text("Timeout, out_valid never came before the cycle limit");
	end

	initial begin
		in_valid    = 1'b0;
		in_valid2   = 1'b0;
		matrix      = '0;
		matrix_size = '0;
		matrix_idx  = '0;
		mode        = MODE_PLAIN;
		cycle_cnt   = 0;
		pulse_cnt   = 0;
		req_done    = 0;
		err_cnt     = 0;
		valid_prev  = 1'b0;
		dim_cur     = 2;
		void'($urandom(32'h9bd2_64b7));

		// 2x2, matrix 6 all -128 and matrix 7 all 127
		stim[0]  = session_row(2'd0, 16'h9000);
		stim[1]  = request_row(0, 1, 2, 0);
		stim[2]  = request_row(3, 4, 5, 0);
		stim[3]  = request_row(1, 1, 1, 0);
		stim[4]  = request_row(2, 0, 2, 0);
		stim[5]  = request_row(6, 7, 6, 0);
		stim[6]  = request_row(7, 6, 7, 0);
		stim[7]  = request_row(6, 6, 6, 0);
		stim[8]  = request_row(7, 7, 6, 0);
		stim[9]  = request_row(5, 3, 0, 0);
		stim[10] = request_row(4, 2, 7, 0);
		// 4x4, matrix 6 all 127 and matrix 7 all -128
		stim[11] = session_row(2'd1, 16'h6000);
		stim[12] = request_row(0, 1, 2, 1);
		stim[13] = request_row(3, 4, 5, 2);
		stim[14] = request_row(5, 6, 7, 3);
		stim[15] = request_row(2, 2, 2, 1);
		stim[16] = request_row(6, 7, 6, 2);
		stim[17] = request_row(7, 6, 7, 3);
		stim[18] = request_row(1, 3, 5, 0);
		stim[19] = request_row(4, 0, 4, 3);
		stim[20] = request_row(7, 7, 6, 1);
		stim[21] = request_row(0, 5, 2, 2);
		// Back to 2x2 after the second session ends
		stim[22] = session_row(2'd0, 16'h0000);
		stim[23] = request_row(1, 2, 3, 3);
		stim[24] = request_row(4, 4, 0, 1);

		wait (rst_n === 1'b1);
		assert (out_valid === 1'b0) else fail_value("out_valid", 0, out_valid);
		assert (out_value === '0) else fail_value("out_value", 0, out_value);

		for (int i = 0; i < NUM_ROWS; i++) begin
			if (stim[i].is_session)
				load_session(stim[i].size_code, stim[i].pats);
			else
				run_request(stim[i]);
		end

		repeat (4) next_cycle();
		assert (pulse_cnt == req_done)
			else fail_text("Extra out_valid pulse seen after the last request");

		if (err_cnt == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== tb_mmt_clkgen.sv ====
`timescale 1ns/1ps

module tb_mmt_clkgen #(
	parameter real PERIOD       = 8.0,
	parameter int  RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

	// Release just after an edge, like the other inputs
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;
	end

endmodule
